/* allocIf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iqCfg_cfg.svh"

interface allocIf;

	logic [`IQ_LANES-1:0] laneWr; // Already qualified by group acceptance
	iqPkg::slotIdx_t [`IQ_LANES-1:0] laneSlot;
	iqPkg::payload_t [`IQ_LANES-1:0] lanePayload;
	iqPkg::tag_t [`IQ_LANES-1:0] laneTag;
	logic [`IQ_LANES-1:0] laneSrcRdy;

	modport ctrl (
		output laneWr, laneSlot, lanePayload, laneTag, laneSrcRdy
	);

	modport store (
		input laneWr, laneSlot, lanePayload, laneTag, laneSrcRdy
	);

endinterface

`default_nettype wire

/* dispatchRank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iqCfg_cfg.svh"

module dispatchRank (
	input wire logic [`IQ_LANES-1:0] en_i,
	output iqPkg::rank_t [`IQ_LANES-1:0] rank_o
);

	// Running count of enabled lanes below the current one
	always_comb begin
		iqPkg::rank_t acc;
		acc = '0;
		for (int l = 0; l < `IQ_LANES; l++) begin
			rank_o[l] = acc;
			acc = acc + iqPkg::rank_t'(en_i[l]); // Wraps only past the top lane
		end
	end

endmodule

`default_nettype wire

/* iqCfg_cfg.svh */
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// The entry count must be a power of two
`define IQ_DEPTH 8

`define IQ_LANES 4 // Dispatch lanes per group

`define IQ_TAG_W 4

`define IQ_PAYLOAD_W 16

`endif

/* iqControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iqCfg_cfg.svh"

module iqControl (
	input wire logic clk_i,
	input wire logic arstN_i,
	input wire logic dispValid_i,
	input wire logic [`IQ_LANES-1:0] dispEn_i,
	input iqPkg::payload_t [`IQ_LANES-1:0] dispPayload_i,
	input iqPkg::tag_t [`IQ_LANES-1:0] dispTag_i,
	input wire logic [`IQ_LANES-1:0] dispSrcRdy_i,
	output logic dispReady_o,
	input iqPkg::rank_t [`IQ_LANES-1:0] rank_i,
	input iqPkg::slotIdx_t [`IQ_LANES-1:0] slot_i,
	input iqPkg::count_t freeCount_i,
	input iqPkg::slotIdx_t grantIdx_i,
	input wire logic grantValid_i,
	input wire logic issueReady_i,
	output logic issueValid_o,
	output logic [`IQ_DEPTH-1:0] valid_o,
	allocIf.ctrl alloc
);

	logic [`IQ_DEPTH-1:0] validQ;
	logic [`IQ_DEPTH-1:0] validNext;
	iqPkg::count_t freeCntQ;
	iqPkg::count_t freeNext;
	iqPkg::count_t wrCount;
	logic accept;
	logic issueFire;
	logic [`IQ_LANES-1:0] laneWr;
	iqPkg::slotIdx_t [`IQ_LANES-1:0] laneSlot;

	assign dispReady_o = (freeCntQ >= iqPkg::count_t'(`IQ_LANES));
	assign accept = dispValid_i & dispReady_o; // An empty lane mask is still a valid group

	assign issueValid_o = grantValid_i;
	assign issueFire = grantValid_i & issueReady_i;

	// Each enabled lane takes the free slot found at its rank
	always_comb begin
		for (int l = 0; l < `IQ_LANES; l++) begin
			laneWr[l] = accept & dispEn_i[l];
			laneSlot[l] = slot_i[rank_i[l]];
		end
	end

	assign alloc.laneWr = laneWr;
	assign alloc.laneSlot = laneSlot;
	assign alloc.lanePayload = dispPayload_i;
	assign alloc.laneTag = dispTag_i;
	assign alloc.laneSrcRdy = dispSrcRdy_i;

	always_comb begin
		wrCount = '0;
		for (int l = 0; l < `IQ_LANES; l++) begin
			wrCount = wrCount + iqPkg::count_t'(laneWr[l]);
		end
	end

	always_comb begin
		validNext = validQ;
		if (issueFire)
			validNext[grantIdx_i] = 1'b0;
		for (int l = 0; l < `IQ_LANES; l++) begin
			if (laneWr[l])
				validNext[laneSlot[l]] = 1'b1;
		end
	end

	// Free count after this edge, so dispReady_o sees issued slots one cycle later
	assign freeNext = freeCount_i - wrCount + iqPkg::count_t'(issueFire);

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			validQ <= '0;
			freeCntQ <= iqPkg::count_t'(`IQ_DEPTH);
		end else begin
			validQ <= validNext;
			freeCntQ <= freeNext;
		end
	end

	assign valid_o = validQ;

endmodule

`default_nettype wire

/* iqPkg.sv */
`default_nettype none

`include "iqCfg_cfg.svh"

package iqPkg;

	// Entry index into the queue
	typedef logic [$clog2(`IQ_DEPTH)-1:0] slotIdx_t;

	typedef logic [$clog2(`IQ_LANES)-1:0] rank_t; // Position among enabled lanes

	typedef logic [`IQ_TAG_W-1:0] tag_t;

	typedef logic [`IQ_PAYLOAD_W-1:0] payload_t;

	// Holds 0 up to IQ_DEPTH inclusive
	typedef logic [$clog2(`IQ_DEPTH+1)-1:0] count_t;

endpackage

`default_nettype wire

/* iqStorage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iqCfg_cfg.svh"

module iqStorage (
	input wire logic clk_i,
	input wire logic arstN_i,
	allocIf.store alloc,
	input wire logic wakeValid_i,
	input iqPkg::tag_t wakeTag_i,
	input wire logic [`IQ_DEPTH-1:0] valid_i,
	input iqPkg::slotIdx_t rdIdx_i,
	output logic [`IQ_DEPTH-1:0] readyMask_o,
	output iqPkg::payload_t rdPayload_o
);

	iqPkg::payload_t payloadMem [`IQ_DEPTH];
	iqPkg::tag_t tagMem [`IQ_DEPTH];
	logic [`IQ_DEPTH-1:0] rdyQ;
	logic [`IQ_LANES-1:0] laneWake;

	// Wakeup also catches lanes arriving in the same edge
	always_comb begin
		for (int l = 0; l < `IQ_LANES; l++) begin
			laneWake[l] = wakeValid_i && (alloc.laneTag[l] == wakeTag_i);
		end
	end

	always_ff @(posedge clk_i) begin
		for (int l = 0; l < `IQ_LANES; l++) begin
			if (alloc.laneWr[l]) begin
				payloadMem[alloc.laneSlot[l]] <= alloc.lanePayload[l];
				tagMem[alloc.laneSlot[l]] <= alloc.laneTag[l];
			end
		end
	end

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			rdyQ <= '0;
		end else begin
			for (int e = 0; e < `IQ_DEPTH; e++) begin
				if (valid_i[e] && wakeValid_i && (tagMem[e] == wakeTag_i))
					rdyQ[e] <= 1'b1;
			end
			// Written lanes take a free slot, so they never clash with a wakeup above
			for (int l = 0; l < `IQ_LANES; l++) begin
				if (alloc.laneWr[l])
					rdyQ[alloc.laneSlot[l]] <= alloc.laneSrcRdy[l] | laneWake[l];
			end
		end
	end

	assign readyMask_o = rdyQ;
	assign rdPayload_o = payloadMem[rdIdx_i];

endmodule

`default_nettype wire

/* issueQueue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iqCfg_cfg.svh"

module issueQueue (
	input wire logic clk_i,
	input wire logic arstN_i,
	input wire logic dispValid_i,
	input wire logic [`IQ_LANES-1:0] dispEn_i,
	input wire logic [`IQ_LANES-1:0][`IQ_PAYLOAD_W-1:0] dispPayload_i,
	input wire logic [`IQ_LANES-1:0][`IQ_TAG_W-1:0] dispTag_i,
	input wire logic [`IQ_LANES-1:0] dispSrcRdy_i,
	output logic dispReady_o,
	input wire logic wakeValid_i,
	input wire logic [`IQ_TAG_W-1:0] wakeTag_i,
	output logic issueValid_o,
	input wire logic issueReady_i,
	output logic [`IQ_PAYLOAD_W-1:0] issuePayload_o
);

	iqPkg::rank_t [`IQ_LANES-1:0] rank;
	iqPkg::slotIdx_t [`IQ_LANES-1:0] slot;
	iqPkg::count_t freeCount;
	iqPkg::slotIdx_t grantIdx;
	iqPkg::payload_t rdPayload;
	logic grantValid;
	logic [`IQ_DEPTH-1:0] validMask;
	logic [`IQ_DEPTH-1:0] readyMask;
	logic [`IQ_DEPTH-1:0] issueReq;

	allocIf allocBus ();

	assign issueReq = validMask & readyMask; // Only live entries with their source ready
	assign issuePayload_o = rdPayload;

	dispatchRank rankUnit (
		.en_i(dispEn_i),
		.rank_o(rank)
	);

	slotFinder finder (
		.freeMask_i(~validMask),
		.slot_o(slot),
		.freeCount_o(freeCount)
	);

	issueSelect select (
		.req_i(issueReq),
		.grantIdx_o(grantIdx),
		.grantValid_o(grantValid)
	);

	iqControl control (
		.clk_i(clk_i),
		.arstN_i(arstN_i),
		.dispValid_i(dispValid_i),
		.dispEn_i(dispEn_i),
		.dispPayload_i(dispPayload_i),
		.dispTag_i(dispTag_i),
		.dispSrcRdy_i(dispSrcRdy_i),
		.dispReady_o(dispReady_o),
		.rank_i(rank),
		.slot_i(slot),
		.freeCount_i(freeCount),
		.grantIdx_i(grantIdx),
		.grantValid_i(grantValid),
		.issueReady_i(issueReady_i),
		.issueValid_o(issueValid_o),
		.valid_o(validMask),
		.alloc(allocBus.ctrl)
	);

	iqStorage storage (
		.clk_i(clk_i),
		.arstN_i(arstN_i),
		.alloc(allocBus.store),
		.wakeValid_i(wakeValid_i),
		.wakeTag_i(wakeTag_i),
		.valid_i(validMask),
		.rdIdx_i(grantIdx),
		.readyMask_o(readyMask),
		.rdPayload_o(rdPayload)
	);

endmodule

`default_nettype wire

/* issueSelect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iqCfg_cfg.svh"

module issueSelect (
	input wire logic [`IQ_DEPTH-1:0] req_i,
	output iqPkg::slotIdx_t grantIdx_o,
	output logic grantValid_o
);

	localparam int IdxW = $clog2(`IQ_DEPTH);

	logic [`IQ_DEPTH-1:0] lowest;

	// Two's complement trick keeps only the lowest request
	assign lowest = req_i & (~req_i + `IQ_DEPTH'(1));

	// Each index bit is the OR of the one-hot positions that have it set
	always_comb begin
		grantIdx_o = '0;
		for (int b = 0; b < IdxW; b++) begin
			for (int i = 0; i < `IQ_DEPTH; i++) begin
				if (((i >> b) & 1) == 1)
					grantIdx_o[b] = grantIdx_o[b] | lowest[i];
			end
		end
	end

	assign grantValid_o = |req_i;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing -f sim.f --top-module tb_issueQueue -o simIssueQueue

out=$(./obj_dir/simIssueQueue)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1

/* sim.f */
+incdir+.
iqPkg.sv
allocIf.sv
dispatchRank.sv
slotFinder.sv
issueSelect.sv
iqStorage.sv
iqControl.sv
issueQueue.sv
tb_issueQueue.sv

/* slotFinder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iqCfg_cfg.svh"

module slotFinder (
	input wire logic [`IQ_DEPTH-1:0] freeMask_i,
	output iqPkg::slotIdx_t [`IQ_LANES-1:0] slot_o,
	output iqPkg::count_t freeCount_o
);

	// Lowest set bit wins; an empty mask gives the top index
	function automatic iqPkg::slotIdx_t encLow(input logic [`IQ_DEPTH-1:0] m);
		iqPkg::slotIdx_t idx;
		idx = '1;
		for (int i = `IQ_DEPTH-1; i >= 0; i--) begin
			if (m[i])
				idx = iqPkg::slotIdx_t'(i);
		end
		return idx;
	endfunction

	// Bits at and below idx are set
	function automatic logic [`IQ_DEPTH-1:0] maskThrough(input iqPkg::slotIdx_t idx);
		logic [`IQ_DEPTH-1:0] m;
		for (int i = 0; i < `IQ_DEPTH; i++) begin
			m[i] = (i <= int'(idx));
		end
		return m;
	endfunction

	always_comb begin
		logic [`IQ_DEPTH-1:0] remaining;
		remaining = freeMask_i;
		for (int r = 0; r < `IQ_LANES; r++) begin
			slot_o[r] = encLow(remaining);
			remaining = remaining & ~maskThrough(slot_o[r]); // Next rank searches above this one
		end
	end

	always_comb begin
		freeCount_o = '0;
		for (int i = 0; i < `IQ_DEPTH; i++) begin
			freeCount_o = freeCount_o + iqPkg::count_t'(freeMask_i[i]);
		end
	end

endmodule

`default_nettype wire

/* tb_issueQueue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "iqCfg_cfg.svh"

module tb_issueQueue;

	localparam int ResetCycles = 3;
	localparam int TestCycles = 2000;
	localparam int TimeoutCycles = TestCycles + TestCycles / 4; // Slack beyond reset and the test
	localparam int StallPeriod = 200;
	localparam int StallLen = 16;

	logic clk;
	logic arstN;
	logic dispValid;
	logic [`IQ_LANES-1:0] dispEn;
	logic [`IQ_LANES-1:0][`IQ_PAYLOAD_W-1:0] dispPayload;
	logic [`IQ_LANES-1:0][`IQ_TAG_W-1:0] dispTag;
	logic [`IQ_LANES-1:0] dispSrcRdy;
	logic dispReady;
	logic wakeValid;
	logic [`IQ_TAG_W-1:0] wakeTag;
	logic issueValid;
	logic issueReady;
	logic [`IQ_PAYLOAD_W-1:0] issuePayload;

	// Reference model of the entries
	logic mValid [`IQ_DEPTH];
	logic mReady [`IQ_DEPTH];
	logic [`IQ_TAG_W-1:0] mTag [`IQ_DEPTH];
	logic [`IQ_PAYLOAD_W-1:0] mPayload [`IQ_DEPTH];

	int errCount;
	int checkCount;
	int cycleCount;
	int modelFires;
	int dutFires;
	logic prevFrozen;
	logic prevValid;
	logic [`IQ_PAYLOAD_W-1:0] prevPayload;

	issueQueue dut_i (
		.clk_i(clk),
		.arstN_i(arstN),
		.dispValid_i(dispValid),
		.dispEn_i(dispEn),
		.dispPayload_i(dispPayload),
		.dispTag_i(dispTag),
		.dispSrcRdy_i(dispSrcRdy),
		.dispReady_o(dispReady),
		.wakeValid_i(wakeValid),
		.wakeTag_i(wakeTag),
		.issueValid_o(issueValid),
		.issueReady_i(issueReady),
		.issuePayload_o(issuePayload)
	);

	always #20 clk = ~clk;

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	function automatic int lowestReady();
		int idx;
		idx = -1;
		for (int e = `IQ_DEPTH - 1; e >= 0; e--) begin
			if (mValid[e] && mReady[e])
				idx = e;
		end
		return idx;
	endfunction

	function automatic int freeEntries();
		int n;
		n = 0;
		for (int e = 0; e < `IQ_DEPTH; e++) begin
			if (!mValid[e])
				n++;
		end
		return n;
	endfunction

	task automatic clearModel();
		for (int e = 0; e < `IQ_DEPTH; e++) begin
			mValid[e] = 1'b0;
			mReady[e] = 1'b0;
			mTag[e] = '0;
			mPayload[e] = '0;
		end
	endtask

	// Advances the model over the next rising edge, using the inputs it will sample
	task automatic modelStep();
		logic oldValid [`IQ_DEPTH];
		int grant;
		int slot;
		logic accept;
		grant = lowestReady();
		accept = dispValid && (freeEntries() >= `IQ_LANES);
		for (int e = 0; e < `IQ_DEPTH; e++) begin
			oldValid[e] = mValid[e];
			if (mValid[e] && wakeValid && (mTag[e] == wakeTag))
				mReady[e] = 1'b1;
		end
		if (grant >= 0 && issueReady) begin
			mValid[grant] = 1'b0;
			modelFires++;
		end
		if (accept) begin
			slot = 0;
			for (int l = 0; l < `IQ_LANES; l++) begin
				if (dispEn[l]) begin
					while (oldValid[slot])
						slot++;
					mValid[slot] = 1'b1;
					mPayload[slot] = dispPayload[l];
					mTag[slot] = dispTag[l];
					mReady[slot] = dispSrcRdy[l] || (wakeValid && (dispTag[l] == wakeTag));
					slot++;
				end
			end
		end
	endtask

	task automatic compareOutputs();
		int grant;
		grant = lowestReady();
		checkEq("dispReady_o", 32'(dispReady), 32'(freeEntries() >= `IQ_LANES));
		checkEq("issueValid_o", 32'(issueValid), 32'(grant >= 0));
		if (grant >= 0)
			checkEq("issuePayload_o", 32'(issuePayload), 32'(mPayload[grant]));
		if (issueValid && issueReady)
			dutFires++;
	endtask

	task automatic driveRandom();
		dispValid <= ($urandom % 4) != 0;
		dispEn <= `IQ_LANES'($urandom);
		dispSrcRdy <= `IQ_LANES'($urandom);
		for (int l = 0; l < `IQ_LANES; l++) begin
			dispPayload[l] <= `IQ_PAYLOAD_W'($urandom);
			dispTag[l] <= `IQ_TAG_W'($urandom % 16);
		end
		wakeValid <= ($urandom % 2) != 0;
		wakeTag <= `IQ_TAG_W'($urandom % 16);
		issueReady <= ($urandom % 4) != 0;
	endtask

	// Nothing moves while this holds, so the issue port must not change
	task automatic holdStall();
		dispValid <= 1'b0;
		wakeValid <= 1'b0;
		issueReady <= 1'b0;
	endtask

	// Outputs are compared at the falling edge, away from the input changes
	always @(negedge clk) begin
		if (!arstN) begin
			clearModel();
			prevFrozen = 1'b0;
		end else begin
			compareOutputs();
			if (prevFrozen) begin
				checkEq("issueValid_o held", 32'(issueValid), 32'(prevValid));
				if (prevValid)
					checkEq("issuePayload_o held", 32'(issuePayload), 32'(prevPayload));
			end
			prevFrozen = !issueReady && !dispValid && !wakeValid;
			prevValid = issueValid;
			prevPayload = issuePayload;
			modelStep();
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("timeout: the run did not end within %0d cycles", TimeoutCycles);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(50));
		errCount = 0;
		checkCount = 0;
		cycleCount = 0;
		modelFires = 0;
		dutFires = 0;
		prevFrozen = 1'b0;
		prevValid = 1'b0;
		prevPayload = '0;
		clk = 1'b0;
		arstN = 1'b0;
		dispValid = 1'b0;
		dispEn = '0;
		dispPayload = '0;
		dispTag = '0;
		dispSrcRdy = '0;
		wakeValid = 1'b0;
		wakeTag = '0;
		issueReady = 1'b0;
		clearModel();
		repeat (ResetCycles) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkEq("dispReady_o after reset", 32'(dispReady), 32'd1);
		checkEq("issueValid_o after reset", 32'(issueValid), 32'd0);
		for (int cyc = 0; cyc < TestCycles; cyc++) begin
			@(posedge clk);
			if ((cyc % StallPeriod) >= (StallPeriod - StallLen))
				holdStall();
			else
				driveRandom();
		end
		@(posedge clk);
		checkEq("issue handshake count", 32'(dutFires), 32'(modelFires));
		$display("checks: %0d  errors: %0d  issued: %0d", checkCount, errCount, dutFires);
		if (errCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
